// File: src.f
verilog/pi_emu_pkg.sv
verilog/jitter_gen.sv
verilog/clk_delay_core.sv
verilog/phase_interpolator.sv
verilog/clk_source.sv
verilog/dt_arbiter.sv
verilog/pi_emu_top.sv
test/pi_emu_assert.sv
test/pi_emu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= pi_emu_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)

# the log decides pass or fail, not the simulator exit status
run: compile
	./$(OBJ_DIR)/$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/pi_emu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pi_emu_tb;

    localparam pi_emu_pkg::dt_t HALF_PERIOD = 16'd260;
    localparam int PH1_EDGES = 16;
    localparam int PH3_LOADS = 8;
    localparam int PH3_GAP   = 3;
    localparam int PH4_EDGES = 16;
    localparam int PH5_EDGES = 12;
    localparam int TOTAL_EDGES = PH1_EDGES + PH3_LOADS * PH3_GAP + PH4_EDGES + PH5_EDGES;
    // one input toggle plus up to a full queue of output edges per half period
    localparam int CYCLES_PER_HALF = 1 + pi_emu_pkg::EDGE_DEPTH;
    localparam int CYCLE_LIMIT = (TOTAL_EDGES + pi_emu_pkg::EDGE_DEPTH + 2) * CYCLES_PER_HALF;
    // the last delay is shorter than a half period, so its edge is out within a few cycles
    localparam int DRAIN_CYCLES = 2 * pi_emu_pkg::EDGE_DEPTH;

    logic              emu_clk;
    logic              rst_n;
    pi_emu_pkg::code_t ctl;
    logic              ctl_valid;
    pi_emu_pkg::dt_t   half_period;
    pi_emu_pkg::jit_t  jitter_amp;
    logic [31:0]       jitter_seed;

    wire               clk_in;
    wire               clk_out_slice;
    pi_emu_pkg::dt_t   emu_dt;
    pi_emu_pkg::time_t emu_time;
    wire               edge_overflow;

    // input edges waiting for their output edge
    pi_emu_pkg::time_t in_time_q [$];
    logic              in_pol_q [$];
    pi_emu_pkg::code_t in_code_q [$];
    int                in_amp_q [$];

    int                in_count;
    int                out_count;
    int                checks;
    int                errors;
    int                cycles;
    pi_emu_pkg::code_t exp_code;
    pi_emu_pkg::time_t last_in_time;
    pi_emu_pkg::time_t last_out_time;
    logic              clk_in_seen;
    logic              clk_out_seen;
    logic [31:0]       lfsr_state;

    pi_emu_top u_dut (
        .emu_clk       (emu_clk),
        .rst_n         (rst_n),
        .ctl           (ctl),
        .ctl_valid     (ctl_valid),
        .half_period   (half_period),
        .jitter_amp    (jitter_amp),
        .jitter_seed   (jitter_seed),
        .clk_in        (clk_in),
        .clk_out_slice (clk_out_slice),
        .emu_dt        (emu_dt),
        .emu_time      (emu_time),
        .edge_overflow (edge_overflow)
    );

    initial emu_clk = 1'b0;
    always #2 emu_clk = ~emu_clk;

    // nominal delay of one edge for a given code
    function automatic pi_emu_pkg::time_t nominal_delay(input pi_emu_pkg::code_t code);
        return pi_emu_pkg::time_t'(pi_emu_pkg::DELAY_BASE)
             + pi_emu_pkg::time_t'(code) * pi_emu_pkg::time_t'(pi_emu_pkg::DELAY_STEP);
    endfunction

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic wait_cycle();
        @(posedge emu_clk);
        #1;
    endtask

    task automatic wait_edges(input int n);
        int target;
        target = in_count + n;
        while (in_count < target) begin
            wait_cycle();
        end
    endtask

    task automatic load_code(input pi_emu_pkg::code_t code);
        ctl       = code;
        ctl_valid = 1'b1;
        wait_cycle();
        ctl_valid = 1'b0;
    endtask

    always @(posedge emu_clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d emu_clk cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    // reference edge model, sampled mid-cycle
    always @(negedge emu_clk) begin : monitor
        pi_emu_pkg::time_t start;
        pi_emu_pkg::time_t elapsed;
        pi_emu_pkg::time_t nominal;
        pi_emu_pkg::time_t lo;
        pi_emu_pkg::time_t hi;
        pi_emu_pkg::time_t bounded;
        pi_emu_pkg::code_t code;
        logic              pol;
        int                amp;
        if (!rst_n) begin
            clk_in_seen  = 1'b0;
            clk_out_seen = 1'b0;
        end else begin
            // input edge captured in this cycle uses the code in force now
            if (clk_in !== clk_in_seen) begin
                check_value("input half period", emu_time - last_in_time, 32'(HALF_PERIOD));
                last_in_time = emu_time;
                clk_in_seen  = clk_in;
                in_time_q.push_back(emu_time);
                in_pol_q.push_back(clk_in);
                in_code_q.push_back(exp_code);
                in_amp_q.push_back(int'(jitter_amp));
                in_count++;
            end
            if (ctl_valid) begin
                exp_code = ctl;
            end
            if (clk_out_slice !== clk_out_seen) begin
                clk_out_seen = clk_out_slice;
                out_count++;
                if (in_time_q.size() == 0) begin
                    errors++;
                    $display("output edge at %0t ns with no pending input edge", $time);
                end else begin
                    start   = in_time_q.pop_front();
                    pol     = in_pol_q.pop_front();
                    code    = in_code_q.pop_front();
                    amp     = in_amp_q.pop_front();
                    elapsed = emu_time - start;
                    nominal = nominal_delay(code);
                    check_value("output polarity", 32'(clk_out_slice), 32'(pol));
                    if (amp == 0) begin
                        check_value("edge delay", elapsed, nominal);
                    end else begin
                        lo      = nominal - pi_emu_pkg::time_t'(amp);
                        hi      = nominal + pi_emu_pkg::time_t'(amp);
                        bounded = (elapsed < lo) ? lo : ((elapsed > hi) ? hi : elapsed);
                        check_value("jittered delay within bound", elapsed, bounded);
                    end
                    check_value("output edge order", 32'(emu_time > last_out_time), 32'd1);
                    last_out_time = emu_time;
                end
            end
        end
    end

    initial begin : stimulus
        logic [31:0] r;
        int          drain;
        rst_n         = 1'b0;
        ctl           = '0;
        ctl_valid     = 1'b0;
        half_period   = HALF_PERIOD;
        jitter_amp    = 8'sd0;
        jitter_seed   = 32'h5a3c_0f91;
        lfsr_state    = 32'h962e;
        in_count      = 0;
        out_count     = 0;
        checks        = 0;
        errors        = 0;
        cycles        = 0;
        exp_code      = '0;
        last_in_time  = '0;
        last_out_time = '0;
        clk_in_seen   = 1'b0;
        clk_out_seen  = 1'b0;

        repeat (2) @(posedge emu_clk);
        check_value("clk_in in reset", 32'(clk_in), 32'd0);
        check_value("clk_out_slice in reset", 32'(clk_out_slice), 32'd0);
        check_value("emu_time in reset", emu_time, 32'd0);
        check_value("edge_overflow in reset", 32'(edge_overflow), 32'd0);
        #1;
        rst_n = 1'b1;

        // fixed code, no jitter, delay above one half period
        load_code(9'd200);
        wait_edges(PH1_EDGES);

        // random codes loaded while edges are in flight
        for (int k = 0; k < PH3_LOADS; k++) begin
            wait_edges(PH3_GAP);
            take_bits(1, r);
            if (r[0]) begin
                wait_cycle();
            end
            take_bits(7, r);
            load_code({2'b01, r[6:0]});
        end

        // fixed code with jitter, amplitude raised once the new code is in
        load_code(9'd192);
        jitter_amp = 8'sd12;
        wait_edges(PH4_EDGES);

        // shorter delay so the queue drains between input edges
        load_code(9'd80);
        wait_edges(PH5_EDGES);

        // give the last captured edge time to come out
        drain = 0;
        while (out_count != in_count && drain < DRAIN_CYCLES) begin
            wait_cycle();
            drain++;
        end

        check_value("edge_overflow at end", 32'(edge_overflow), 32'd0);
        check_value("input and output edge counts", out_count, in_count);
        $display("checks %0d, failed checks %0d, assertion failures %0d, edges in %0d, out %0d",
                 checks, errors, u_dut.u_assert.fail_count, in_count, out_count);
        if (errors == 0 && u_dut.u_assert.fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/pi_emu_assert.sv
`timescale 1ns/1ps
`default_nettype none

module pi_emu_assert (
    input wire logic              emu_clk,
    input wire logic              rst_n,
    input wire logic              clk_in,
    input wire logic              clk_out_slice,
    input wire pi_emu_pkg::dt_t   emu_dt,
    input wire pi_emu_pkg::time_t emu_time
);

    logic        clk_in_q;
    logic        clk_out_q;
    logic [31:0] in_edges;
    logic [31:0] out_edges;

    // read by the testbench when the run closes
    int fail_count = 0;

    // captured input edges versus delivered output edges
    always_ff @(posedge emu_clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_in_q  <= 1'b0;
            clk_out_q <= 1'b0;
            in_edges  <= '0;
            out_edges <= '0;
        end else begin
            clk_in_q  <= clk_in;
            clk_out_q <= clk_out_slice;
            if (clk_in != clk_in_q) begin
                in_edges <= in_edges + 32'd1;
            end
            if (clk_out_slice != clk_out_q) begin
                out_edges <= out_edges + 32'd1;
            end
        end
    end

    step_in_range: assert property (@(posedge emu_clk) disable iff (!rst_n)
        emu_dt != '0 && emu_dt <= pi_emu_pkg::DT_MAX)
    else begin
        $error("emu_dt out of range: %0d", emu_dt);
        fail_count++;
    end

    time_accumulates: assert property (@(posedge emu_clk) disable iff (!rst_n)
        $past(rst_n) |->
        emu_time == $past(emu_time) + pi_emu_pkg::time_t'($past(emu_dt)))
    else begin
        $error("emu_time did not advance by the granted step");
        fail_count++;
    end

    // an output edge needs an input edge captured before it
    output_after_capture: assert property (@(posedge emu_clk) disable iff (!rst_n)
        clk_out_slice != clk_out_q |-> in_edges > out_edges)
    else begin
        $error("clk_out_slice changed with no captured input edge pending");
        fail_count++;
    end

endmodule

bind pi_emu_top pi_emu_assert u_assert (
    .emu_clk       (emu_clk),
    .rst_n         (rst_n),
    .clk_in        (clk_in),
    .clk_out_slice (clk_out_slice),
    .emu_dt        (emu_dt),
    .emu_time      (emu_time)
);

`default_nettype wire

// File: verilog/pi_emu_top.sv
`timescale 1ns/1ps
`default_nettype none

module pi_emu_top (
    input  wire logic              emu_clk,
    input  wire logic              rst_n,
    input  wire pi_emu_pkg::code_t ctl,
    input  wire logic              ctl_valid,
    input  wire pi_emu_pkg::dt_t   half_period,
    input  wire pi_emu_pkg::jit_t  jitter_amp,
    input  wire logic [31:0]       jitter_seed,
    output wire logic              clk_in,
    output wire logic              clk_out_slice,
    output wire pi_emu_pkg::dt_t   emu_dt,
    output wire pi_emu_pkg::time_t emu_time,
    output wire logic              edge_overflow
);

    wire pi_emu_pkg::dt_t src_dt_req;
    wire pi_emu_pkg::dt_t core_dt_req;

    clk_source clk_source_i (
        .emu_clk     (emu_clk),
        .rst_n       (rst_n),
        .half_period (half_period),
        .emu_dt      (emu_dt),
        .clk_val     (clk_in),
        .dt_req      (src_dt_req)
    );

    phase_interpolator phase_interpolator_i (
        .emu_clk       (emu_clk),
        .rst_n         (rst_n),
        .ctl           (ctl),
        .ctl_valid     (ctl_valid),
        .clk_in        (clk_in),
        .jitter_amp    (jitter_amp),
        .jitter_seed   (jitter_seed),
        .emu_dt        (emu_dt),
        .clk_out_slice (clk_out_slice),
        .dt_req        (core_dt_req),
        .edge_overflow (edge_overflow)
    );

    // one grant per cycle for both timed blocks
    dt_arbiter dt_arbiter_i (
        .emu_clk     (emu_clk),
        .rst_n       (rst_n),
        .src_dt_req  (src_dt_req),
        .core_dt_req (core_dt_req),
        .emu_dt      (emu_dt),
        .emu_time    (emu_time)
    );

endmodule

`default_nettype wire

// File: verilog/dt_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module dt_arbiter (
    input  wire logic            emu_clk,
    input  wire logic            rst_n,
    input  wire pi_emu_pkg::dt_t src_dt_req,
    input  wire pi_emu_pkg::dt_t core_dt_req,
    output pi_emu_pkg::dt_t      emu_dt,
    output pi_emu_pkg::time_t    emu_time
);

    pi_emu_pkg::dt_t req_min;

    // smallest request wins, never more than DT_MAX
    assign req_min = (src_dt_req < core_dt_req) ? src_dt_req : core_dt_req;
    assign emu_dt  = (req_min < pi_emu_pkg::DT_MAX) ? req_min : pi_emu_pkg::DT_MAX;

    always_ff @(posedge emu_clk or negedge rst_n) begin
        if (!rst_n) begin
            emu_time <= '0;
        end else begin
            emu_time <= emu_time + pi_emu_pkg::time_t'(emu_dt);
        end
    end

endmodule

`default_nettype wire

// File: verilog/clk_source.sv
`timescale 1ns/1ps
`default_nettype none

module clk_source (
    input  wire logic            emu_clk,
    input  wire logic            rst_n,
    input  wire pi_emu_pkg::dt_t half_period,
    input  wire pi_emu_pkg::dt_t emu_dt,
    output logic                 clk_val,
    output pi_emu_pkg::dt_t      dt_req
);

    pi_emu_pkg::dt_t cnt;
    pi_emu_pkg::dt_t cnt_dec;
    pi_emu_pkg::dt_t reload;

    // a zero half period would stall time, so run at the 1 ps minimum
    assign reload = (half_period == '0) ? pi_emu_pkg::dt_t'(1) : half_period;

    assign cnt_dec = cnt - emu_dt;

    // distance to the next toggle
    assign dt_req = cnt;

    always_ff @(posedge emu_clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt     <= reload;
            clk_val <= 1'b0;
        end else if (cnt_dec == '0) begin
            cnt     <= reload;
            clk_val <= ~clk_val;
        end else begin
            cnt <= cnt_dec;
        end
    end

endmodule

`default_nettype wire

// File: verilog/phase_interpolator.sv
`timescale 1ns/1ps
`default_nettype none

module phase_interpolator (
    input  wire logic              emu_clk,
    input  wire logic              rst_n,
    input  wire pi_emu_pkg::code_t ctl,
    input  wire logic              ctl_valid,
    input  wire logic              clk_in,
    input  wire pi_emu_pkg::jit_t  jitter_amp,
    input  wire logic [31:0]       jitter_seed,
    input  wire pi_emu_pkg::dt_t   emu_dt,
    output wire logic              clk_out_slice,
    output wire pi_emu_pkg::dt_t   dt_req,
    output wire logic              edge_overflow
);

    pi_emu_pkg::code_t code_q;
    pi_emu_pkg::jit_t  jitter;
    logic              jitter_next;

    // code takes effect for edges captured after the load cycle
    always_ff @(posedge emu_clk or negedge rst_n) begin
        if (!rst_n) begin
            code_q <= '0;
        end else if (ctl_valid) begin
            code_q <= ctl;
        end
    end

    jitter_gen jitter_gen_i (
        .emu_clk (emu_clk),
        .rst_n   (rst_n),
        .seed    (jitter_seed),
        .amp     (jitter_amp),
        .next    (jitter_next),
        .offset  (jitter)
    );

    clk_delay_core clk_delay_core_i (
        // code in, delayed clock out
        .code        (code_q),
        .clk_i_val   (clk_in),
        .clk_o_val   (clk_out_slice),
        .overflow    (edge_overflow),
        // one offset per captured edge
        .jitter      (jitter),
        .jitter_next (jitter_next),
        // step request and grant
        .dt_req      (dt_req),
        .emu_dt      (emu_dt),
        .emu_clk     (emu_clk),
        .rst_n       (rst_n)
    );

endmodule

`default_nettype wire

// File: verilog/clk_delay_core.sv
`timescale 1ns/1ps
`default_nettype none

module clk_delay_core (
    input  wire  logic              emu_clk,
    input  wire  logic              rst_n,
    input  wire  pi_emu_pkg::code_t code,
    input  wire  logic              clk_i_val,
    input  wire  pi_emu_pkg::jit_t  jitter,
    input  wire  pi_emu_pkg::dt_t   emu_dt,
    output logic                    jitter_next,
    output pi_emu_pkg::dt_t         dt_req,
    output logic                    clk_o_val,
    output logic                    overflow
);

    logic                                        clk_i_q;
    logic [pi_emu_pkg::EDGE_DEPTH-1:0]           q_pol;
    pi_emu_pkg::dt_t                             q_rem [pi_emu_pkg::EDGE_DEPTH];
    logic [$clog2(pi_emu_pkg::EDGE_DEPTH+1)-1:0] q_cnt;

    logic                                        edge_seen;
    logic                                        push;
    logic                                        fire;
    logic                                        fire_pol;
    pi_emu_pkg::dt_t                             delay_nom;
    pi_emu_pkg::dt_t                             tail_rem;
    pi_emu_pkg::dt_t                             new_rem;
    logic [pi_emu_pkg::EDGE_DEPTH-1:0]           n_pol;
    pi_emu_pkg::dt_t                             n_rem [pi_emu_pkg::EDGE_DEPTH];
    logic [$clog2(pi_emu_pkg::EDGE_DEPTH+1)-1:0] n_cnt;

    assign edge_seen   = clk_i_val != clk_i_q;
    assign push        = edge_seen && (q_cnt != pi_emu_pkg::EDGE_DEPTH);
    assign jitter_next = push;

    // base + code * step + jitter, jitter sign extended
    assign delay_nom = pi_emu_pkg::DELAY_BASE
                     + pi_emu_pkg::dt_t'(code) * pi_emu_pkg::DELAY_STEP
                     + pi_emu_pkg::dt_t'(jitter);

    always_comb begin
        tail_rem = '0;
        for (int i = 0; i < pi_emu_pkg::EDGE_DEPTH; i++) begin
            if (q_cnt == i + 1) begin
                tail_rem = q_rem[i];
            end
        end
    end

    // keep edges in order, a new edge lands strictly after the tail
    assign new_rem = (q_cnt != 0 && delay_nom <= tail_rem) ?
                     tail_rem + pi_emu_pkg::dt_t'(1) : delay_nom;

    // head is always the nearest event, a new entry only matters when empty
    assign dt_req = (q_cnt != 0) ? q_rem[0] :
                    (push ? new_rem : pi_emu_pkg::DT_MAX);

    always_comb begin
        n_pol = q_pol;
        n_rem = q_rem;
        n_cnt = q_cnt;

        // append at the tail
        if (push) begin
            for (int i = 0; i < pi_emu_pkg::EDGE_DEPTH; i++) begin
                if (q_cnt == i) begin
                    n_pol[i] = clk_i_val;
                    n_rem[i] = new_rem;
                end
            end
            n_cnt = q_cnt + 1'b1;
        end

        // every live entry ages by the granted step
        for (int i = 0; i < pi_emu_pkg::EDGE_DEPTH; i++) begin
            if (i < n_cnt) begin
                n_rem[i] = n_rem[i] - emu_dt;
            end
        end

        fire     = (n_cnt != 0) && (n_rem[0] == '0);
        fire_pol = n_pol[0];

        // pop the head once it is due
        if (fire) begin
            for (int i = 0; i < pi_emu_pkg::EDGE_DEPTH - 1; i++) begin
                n_pol[i] = n_pol[i+1];
                n_rem[i] = n_rem[i+1];
            end
            n_cnt = n_cnt - 1'b1;
        end
    end

    always_ff @(posedge emu_clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_i_q   <= 1'b0;
            q_cnt     <= '0;
            clk_o_val <= 1'b0;
            overflow  <= 1'b0;
        end else begin
            clk_i_q <= clk_i_val;
            q_cnt   <= n_cnt;
            if (fire) begin
                clk_o_val <= fire_pol;
            end
            // dropped edge, sticky until reset
            if (edge_seen && !push) begin
                overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge emu_clk) begin
        q_pol <= n_pol;
        q_rem <= n_rem;
    end

endmodule

`default_nettype wire

// File: verilog/jitter_gen.sv
`timescale 1ns/1ps
`default_nettype none

module jitter_gen (
    input  wire  logic             emu_clk,
    input  wire  logic             rst_n,
    input  wire  logic [31:0]      seed,
    input  wire  pi_emu_pkg::jit_t amp,
    input  wire  logic             next,
    output pi_emu_pkg::jit_t       offset
);

    logic [31:0]      lfsr;
    logic [31:0]      seed_safe;
    logic             feedback;
    pi_emu_pkg::jit_t amp_lim;
    logic [4:0]       span;
    logic [4:0]       fold;

    // an all-zero state would lock the lfsr
    assign seed_safe = (seed == 32'h0) ? 32'h1 : seed;

    // taps 32, 22, 2, 1
    assign feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];

    always_ff @(posedge emu_clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr <= seed_safe;
        end else if (next) begin
            lfsr <= {lfsr[30:0], feedback};
        end
    end

    // negative amplitudes count as zero, large ones saturate
    always_comb begin
        if (amp[7]) begin
            amp_lim = '0;
        end else if (amp > pi_emu_pkg::JIT_AMP_MAX) begin
            amp_lim = pi_emu_pkg::JIT_AMP_MAX;
        end else begin
            amp_lim = amp;
        end
    end

    // 2*amp+1 possible offsets, from -amp to +amp
    assign span = {amp_lim[3:0], 1'b1};
    assign fold = 5'(lfsr[7:0] % span);

    assign offset = pi_emu_pkg::jit_t'(fold) - amp_lim;

endmodule

`default_nettype wire

// File: verilog/pi_emu_pkg.sv
`default_nettype none

package pi_emu_pkg;

    // one time step or a time distance, in ps
    typedef logic [15:0] dt_t;

    // accumulated emulated time, in ps
    typedef logic [31:0] time_t;

    // delay code of the interpolator
    typedef logic [8:0] code_t;

    // signed jitter offset, in ps
    typedef logic signed [7:0] jit_t;

    // largest step the arbiter will ever grant
    localparam dt_t DT_MAX = 16'h7fff;

    // delay added per code lsb, in ps
    localparam dt_t DELAY_STEP = 16'd2;

    // intrinsic delay at code zero; stays above JIT_AMP_MAX so delays remain positive
    localparam dt_t DELAY_BASE = 16'd20;

    // edges that may be in flight through the delay line
    localparam int EDGE_DEPTH = 4;

    // upper bound on the jitter amplitude
    localparam jit_t JIT_AMP_MAX = 8'sd15;

endpackage

`default_nettype wire
